/* cfg_axil_regs.sv */
`timescale 1ns/1ns
`include "pcie_chk_cfg.svh"

module cfg_axil_regs (
  input  logic                                          sys_clk,
  input  logic                                          rst_n,
  cfg_if.snk                                            snap,
  input  pcie_chk_pkg::evt_cnt_t [`PCHK_EVT_COUNT-1:0] cnt,
  output pcie_chk_pkg::evt_vec_t                        cnt_clr,

  input  logic [`PCHK_ADDR_W-1:0]                       awaddr,
  input  logic                                          awvalid,
  output logic                                          awready,
  input  logic [`PCHK_DATA_W-1:0]                       wdata,
  input  logic [`PCHK_DATA_W/8-1:0]                     wstrb,
  input  logic                                          wvalid,
  output logic                                          wready,
  output logic [1:0]                                    bresp,
  output logic                                          bvalid,
  input  logic                                          bready,
  input  logic [`PCHK_ADDR_W-1:0]                       araddr,
  input  logic                                          arvalid,
  output logic                                          arready,
  output logic [`PCHK_DATA_W-1:0]                       rdata,
  output logic [1:0]                                    rresp,
  output logic                                          rvalid,
  input  logic                                          rready
);

  pcie_chk_pkg::axil_state_e              wr_state;
  pcie_chk_pkg::axil_state_e              rd_state;
  logic                                   wr_accept;
  logic                                   rd_accept;
  logic                                   cnt_hit;
  logic [`PCHK_ADDR_W-1:0]                cnt_off;
  logic [$clog2(`PCHK_EVT_COUNT)-1:0]     cnt_lane;
  logic [`PCHK_DATA_W-1:0]                rd_word;

  // address and data taken together, only while no response is pending
  assign wr_accept = (wr_state == pcie_chk_pkg::axil_idle) && awvalid && wvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign bvalid    = (wr_state == pcie_chk_pkg::axil_resp);
  assign bresp     = 2'b00;

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      wr_state <= pcie_chk_pkg::axil_idle;
      cnt_clr  <= '0;
    end else begin
      cnt_clr <= '0;
      case (wr_state)
        pcie_chk_pkg::axil_idle: begin
          if (wr_accept) begin
            wr_state <= pcie_chk_pkg::axil_resp;
            if (awaddr == `PCHK_REG_CLR && wstrb[0]) begin
              cnt_clr <= wdata[`PCHK_EVT_COUNT-1:0];
            end
          end
        end
        default: begin
          if (bready) begin
            wr_state <= pcie_chk_pkg::axil_idle;
          end
        end
      endcase
    end
  end

  assign rd_accept = (rd_state == pcie_chk_pkg::axil_idle) && arvalid;
  assign arready   = rd_accept;
  assign rvalid    = (rd_state == pcie_chk_pkg::axil_resp);
  assign rresp     = 2'b00;

  // counter window, one word per lane
  assign cnt_off  = araddr - `PCHK_REG_CNT0;
  assign cnt_lane = cnt_off[$clog2(`PCHK_EVT_COUNT)+1:2];
  assign cnt_hit  = (araddr >= `PCHK_REG_CNT0) &&
                    (araddr < `PCHK_REG_CNT0 + 4 * `PCHK_EVT_COUNT) &&
                    (araddr[1:0] == 2'b00);

  always_comb begin
    rd_word = '0;
    case (araddr)
      `PCHK_REG_ID:   rd_word = {16'h0000, snap.bus_num, snap.dev_num, snap.fn_num};
      `PCHK_REG_CMD:  rd_word = {snap.dstatus, snap.command};
      `PCHK_REG_DCMD: rd_word = {snap.dcommand2, snap.dcommand};
      `PCHK_REG_LNK:  rd_word = {snap.lstatus, snap.lcommand};
      default: begin
        if (cnt_hit) begin
          rd_word = {{(`PCHK_DATA_W - `PCHK_CNT_W){1'b0}}, cnt[cnt_lane]};
        end
      end
    endcase
  end

  // rdata is held from acceptance until rready
  always_ff @(posedge sys_clk) begin
    if (rd_accept) begin
      rdata <= rd_word;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      rd_state <= pcie_chk_pkg::axil_idle;
    end else begin
      case (rd_state)
        pcie_chk_pkg::axil_idle: begin
          if (rd_accept) begin
            rd_state <= pcie_chk_pkg::axil_resp;
          end
        end
        default: begin
          if (rready) begin
            rd_state <= pcie_chk_pkg::axil_idle;
          end
        end
      endcase
    end
  end

endmodule

/* cfg_event_detect.sv */
`timescale 1ns/1ns
`include "pcie_chk_cfg.svh"

module cfg_event_detect (
  input  logic                                          sys_clk,
  input  logic                                          rst_n,
  cfg_if.snk                                            snap,
  input  logic                                          mode_ack,
  input  logic                                          sys_rst_req,
  input  pcie_chk_pkg::evt_vec_t                        cnt_clr,
  output pcie_chk_pkg::evt_vec_t                        evt,
  output pcie_chk_pkg::evt_cnt_t [`PCHK_EVT_COUNT-1:0] cnt
);

  pcie_chk_pkg::bus_num_t  prev_bus;
  pcie_chk_pkg::dev_num_t  prev_dev;
  pcie_chk_pkg::fn_num_t   prev_fn;
  pcie_chk_pkg::cfg_word_t prev_command;
  pcie_chk_pkg::cfg_word_t prev_lstatus;
  logic [3:0]              prev_derr;
  logic                    prev_mode_ack;
  logic                    prev_sys_rst;
  pcie_chk_pkg::evt_vec_t  hit;

  // delayed copy, free running so it matches the snapshot right after reset
  always_ff @(posedge sys_clk) begin
    prev_bus      <= snap.bus_num;
    prev_dev      <= snap.dev_num;
    prev_fn       <= snap.fn_num;
    prev_command  <= snap.command;
    prev_lstatus  <= snap.lstatus;
    prev_derr     <= snap.dstatus[3:0];
    prev_mode_ack <= mode_ack;
    prev_sys_rst  <= sys_rst_req;
  end

  always_comb begin
    hit = '0;
    hit[pcie_chk_pkg::evt_id_chg]   = {snap.bus_num, snap.dev_num, snap.fn_num} !=
                                      {prev_bus, prev_dev, prev_fn};
    hit[pcie_chk_pkg::evt_cmd_chg]  = snap.command != prev_command;
    // only error bits 3:0, rising only
    hit[pcie_chk_pkg::evt_derr]     = |(snap.dstatus[3:0] & ~prev_derr);
    hit[pcie_chk_pkg::evt_lnk_chg]  = snap.lstatus != prev_lstatus;
    hit[pcie_chk_pkg::evt_mode_ack] = mode_ack & ~prev_mode_ack;
    hit[pcie_chk_pkg::evt_sys_rst]  = sys_rst_req & ~prev_sys_rst;
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      evt <= '0;
    end else begin
      evt <= hit;
    end
  end

  // saturating counters, clear beats a same-edge increment
  always_ff @(posedge sys_clk) begin
    for (int i = 0; i < `PCHK_EVT_COUNT; i++) begin
      if (!rst_n || cnt_clr[i]) begin
        cnt[i] <= '0;
      end else if (hit[i] && cnt[i] != '1) begin
        cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

endmodule

/* cfg_if.sv */
`timescale 1ns/1ns

// synchronized config snapshot, sys_clk domain
interface cfg_if;
  pcie_chk_pkg::bus_num_t bus_num;
  pcie_chk_pkg::dev_num_t dev_num;
  pcie_chk_pkg::fn_num_t fn_num;
  pcie_chk_pkg::cfg_word_t command;
  pcie_chk_pkg::cfg_word_t dstatus;
  pcie_chk_pkg::cfg_word_t dcommand;
  pcie_chk_pkg::cfg_word_t lstatus;
  pcie_chk_pkg::cfg_word_t lcommand;
  pcie_chk_pkg::cfg_word_t dcommand2;

  modport src (
    output bus_num, dev_num, fn_num, command, dstatus,
    output dcommand, lstatus, lcommand, dcommand2
  );

  modport snk (
    input bus_num, dev_num, fn_num, command, dstatus,
    input dcommand, lstatus, lcommand, dcommand2
  );

endinterface

/* cfg_sync.sv */
`timescale 1ns/1ns

module cfg_sync (
  input  logic                      sys_clk,
  input  pcie_chk_pkg::bus_num_t    trn_bus_number,
  input  pcie_chk_pkg::dev_num_t    trn_device_number,
  input  pcie_chk_pkg::fn_num_t     trn_function_number,
  input  pcie_chk_pkg::cfg_word_t   trn_command,
  input  pcie_chk_pkg::cfg_word_t   trn_dstatus,
  input  pcie_chk_pkg::cfg_word_t   trn_dcommand,
  input  pcie_chk_pkg::cfg_word_t   trn_lstatus,
  input  pcie_chk_pkg::cfg_word_t   trn_lcommand,
  input  pcie_chk_pkg::cfg_word_t   trn_dcommand2,
  cfg_if.src                        snap
);

  // first stage, may go metastable
  pcie_chk_pkg::bus_num_t  bus_num_m;
  pcie_chk_pkg::dev_num_t  dev_num_m;
  pcie_chk_pkg::fn_num_t   fn_num_m;
  pcie_chk_pkg::cfg_word_t command_m;
  pcie_chk_pkg::cfg_word_t dstatus_m;
  pcie_chk_pkg::cfg_word_t dcommand_m;
  pcie_chk_pkg::cfg_word_t lstatus_m;
  pcie_chk_pkg::cfg_word_t lcommand_m;
  pcie_chk_pkg::cfg_word_t dcommand2_m;

  // fields are quasi-static, each bit settles on its own
  always_ff @(posedge sys_clk) begin
    bus_num_m      <= trn_bus_number;
    dev_num_m      <= trn_device_number;
    fn_num_m       <= trn_function_number;
    command_m      <= trn_command;
    dstatus_m      <= trn_dstatus;
    dcommand_m     <= trn_dcommand;
    lstatus_m      <= trn_lstatus;
    lcommand_m     <= trn_lcommand;
    dcommand2_m    <= trn_dcommand2;
    snap.bus_num   <= bus_num_m;
    snap.dev_num   <= dev_num_m;
    snap.fn_num    <= fn_num_m;
    snap.command   <= command_m;
    snap.dstatus   <= dstatus_m;
    snap.dcommand  <= dcommand_m;
    snap.lstatus   <= lstatus_m;
    snap.lcommand  <= lcommand_m;
    snap.dcommand2 <= dcommand2_m;
  end

endmodule

/* evt_pulse_sync.sv */
`timescale 1ns/1ns

module evt_pulse_sync (
  input  logic sys_clk,
  input  logic mpu_clk,
  input  logic rst_n,
  input  logic pulse_in,
  output logic pulse_out
);

  logic       src_tgl;
  logic [2:0] dst_sync;

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      src_tgl <= 1'b0;
    end else if (pulse_in) begin
      src_tgl <= ~src_tgl;
    end
  end

  // bit 0 is the metastable catcher
  always_ff @(posedge mpu_clk) begin
    if (!rst_n) begin
      dst_sync <= '0;
    end else begin
      dst_sync <= {dst_sync[1:0], src_tgl};
    end
  end

  assign pulse_out = dst_sync[2] ^ dst_sync[1];

endmodule

/* list.f */
+incdir+.
pcie_chk_pkg.sv
cfg_if.sv
cfg_sync.sv
cfg_event_detect.sv
evt_pulse_sync.sv
mpu_event_latch.sv
cfg_axil_regs.sv
pcie_cfg_checker.sv
pcie_cfg_checker_props.sv
tb_clkgen.sv
tb_pcie_cfg_checker.sv

/* mpu_event_latch.sv */
`timescale 1ns/1ns

module mpu_event_latch (
  input  logic                   mpu_clk,
  input  logic                   rst_n,
  input  pcie_chk_pkg::evt_vec_t evt,
  input  pcie_chk_pkg::evt_vec_t clear,
  output pcie_chk_pkg::evt_vec_t flags,
  output logic                   mode_ack_pulse,
  output logic                   sys_rst_pulse
);

  // a new pulse wins over a clear
  always_ff @(posedge mpu_clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else begin
      flags <= (flags & ~clear) | evt;
    end
  end

  always_ff @(posedge mpu_clk) begin
    if (!rst_n) begin
      mode_ack_pulse <= 1'b0;
      sys_rst_pulse  <= 1'b0;
    end else begin
      mode_ack_pulse <= evt[pcie_chk_pkg::evt_mode_ack];
      sys_rst_pulse  <= evt[pcie_chk_pkg::evt_sys_rst];
    end
  end

endmodule

/* pcie_cfg_checker.sv */
`timescale 1ns/1ns
`include "pcie_chk_cfg.svh"

module pcie_cfg_checker (
  input  logic                     sys_clk,
  input  logic                     trn_clk,
  input  logic                     mpu_clk,
  input  logic                     rst_n,

  input  pcie_chk_pkg::bus_num_t   trn_bus_number,
  input  pcie_chk_pkg::dev_num_t   trn_device_number,
  input  pcie_chk_pkg::fn_num_t    trn_function_number,
  input  pcie_chk_pkg::cfg_word_t  trn_command,
  input  pcie_chk_pkg::cfg_word_t  trn_dstatus,
  input  pcie_chk_pkg::cfg_word_t  trn_dcommand,
  input  pcie_chk_pkg::cfg_word_t  trn_lstatus,
  input  pcie_chk_pkg::cfg_word_t  trn_lcommand,
  input  pcie_chk_pkg::cfg_word_t  trn_dcommand2,

  input  logic                     mode_ack,
  input  logic                     sys_rst_req,

  input  logic [`PCHK_ADDR_W-1:0]  awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [`PCHK_DATA_W-1:0]  wdata,
  input  logic [`PCHK_DATA_W/8-1:0] wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [`PCHK_ADDR_W-1:0]  araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [`PCHK_DATA_W-1:0]  rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,

  input  pcie_chk_pkg::evt_vec_t   mpu_evt_clear,
  output pcie_chk_pkg::evt_vec_t   mpu_evt_flags,
  output logic                     mpu_mode_ack,
  output logic                     mpu_sys_rst
);

  pcie_chk_pkg::evt_vec_t                        sys_evt;
  pcie_chk_pkg::evt_vec_t                        mpu_evt;
  pcie_chk_pkg::evt_vec_t                        cnt_clr;
  pcie_chk_pkg::evt_cnt_t [`PCHK_EVT_COUNT-1:0] evt_cnt;

  cfg_if u_snap ();

  // trn_clk only launches the fields, the capture runs on sys_clk
  cfg_sync u_cfg_sync (
    .sys_clk             (sys_clk),
    .trn_bus_number      (trn_bus_number),
    .trn_device_number   (trn_device_number),
    .trn_function_number (trn_function_number),
    .trn_command         (trn_command),
    .trn_dstatus         (trn_dstatus),
    .trn_dcommand        (trn_dcommand),
    .trn_lstatus         (trn_lstatus),
    .trn_lcommand        (trn_lcommand),
    .trn_dcommand2       (trn_dcommand2),
    .snap                (u_snap.src)
  );

  cfg_event_detect u_detect (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .snap        (u_snap.snk),
    .mode_ack    (mode_ack),
    .sys_rst_req (sys_rst_req),
    .cnt_clr     (cnt_clr),
    .evt         (sys_evt),
    .cnt         (evt_cnt)
  );

  for (genvar i = 0; i < `PCHK_EVT_COUNT; i++) begin : g_lane
    evt_pulse_sync u_psync (
      .sys_clk   (sys_clk),
      .mpu_clk   (mpu_clk),
      .rst_n     (rst_n),
      .pulse_in  (sys_evt[i]),
      .pulse_out (mpu_evt[i])
    );
  end

  mpu_event_latch u_latch (
    .mpu_clk        (mpu_clk),
    .rst_n          (rst_n),
    .evt            (mpu_evt),
    .clear          (mpu_evt_clear),
    .flags          (mpu_evt_flags),
    .mode_ack_pulse (mpu_mode_ack),
    .sys_rst_pulse  (mpu_sys_rst)
  );

  cfg_axil_regs u_regs (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .snap    (u_snap.snk),
    .cnt     (evt_cnt),
    .cnt_clr (cnt_clr),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

endmodule

/* pcie_cfg_checker_props.sv */
`timescale 1ns/1ns
`include "pcie_chk_cfg.svh"

module pcie_cfg_checker_props (
  input logic                    sys_clk,
  input logic                    mpu_clk,
  input logic                    rst_n,
  input logic [`PCHK_ADDR_W-1:0] awaddr,
  input logic                    awvalid,
  input logic                    awready,
  input logic                    wvalid,
  input logic                    wready,
  input logic                    bvalid,
  input logic                    bready,
  input logic [`PCHK_ADDR_W-1:0] araddr,
  input logic                    arvalid,
  input logic                    arready,
  input logic                    rvalid,
  input logic                    rready,
  input logic                    mpu_mode_ack
);

  // valid and payload hold until the beat completes
  aw_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awvalid or awaddr changed before awready");
  w_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid)
    else $error("wvalid dropped before wready");
  ar_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid or araddr changed before arready");
  b_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");
  r_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  b_after_wr: assert property (@(posedge sys_clk) disable iff (!rst_n)
    awvalid && awready |=> bvalid)
    else $error("no bvalid after write acceptance");
  r_after_rd: assert property (@(posedge sys_clk) disable iff (!rst_n)
    arvalid && arready |=> rvalid)
    else $error("no rvalid after read acceptance");

  mode_ack_single: assert property (@(posedge mpu_clk) disable iff (!rst_n)
    mpu_mode_ack |=> !mpu_mode_ack)
    else $error("mpu_mode_ack high for two mpu cycles");

endmodule

// top level holds both the AXI4-Lite ports and the mpu pulse
bind pcie_cfg_checker pcie_cfg_checker_props u_props (
  .sys_clk      (sys_clk),
  .mpu_clk      (mpu_clk),
  .rst_n        (rst_n),
  .awaddr       (awaddr),
  .awvalid      (awvalid),
  .awready      (awready),
  .wvalid       (wvalid),
  .wready       (wready),
  .bvalid       (bvalid),
  .bready       (bready),
  .araddr       (araddr),
  .arvalid      (arvalid),
  .arready      (arready),
  .rvalid       (rvalid),
  .rready       (rready),
  .mpu_mode_ack (mpu_mode_ack)
);

/* pcie_chk_cfg.svh */
`ifndef PCHK_CFG_SVH
`define PCHK_CFG_SVH

// event lanes, fixed by the lane meanings
`define PCHK_EVT_COUNT 6
`define PCHK_CNT_W 16
`define PCHK_ADDR_W 8
`define PCHK_DATA_W 32

`define PCHK_REG_ID 8'h00
`define PCHK_REG_CMD 8'h04
`define PCHK_REG_DCMD 8'h08
`define PCHK_REG_LNK 8'h0C
`define PCHK_REG_CNT0 8'h10
`define PCHK_REG_CLR 8'h30

`endif

/* pcie_chk_pkg.sv */
`include "pcie_chk_cfg.svh"

package pcie_chk_pkg;

  typedef logic [7:0] bus_num_t;
  typedef logic [4:0] dev_num_t;
  typedef logic [2:0] fn_num_t;
  typedef logic [15:0] cfg_word_t;

  typedef logic [`PCHK_EVT_COUNT-1:0] evt_vec_t;
  typedef logic [`PCHK_CNT_W-1:0] evt_cnt_t;

  // lane order, also the counter register order
  typedef enum logic [2:0] {
    evt_id_chg   = 3'd0,
    evt_cmd_chg  = 3'd1,
    evt_derr     = 3'd2,
    evt_lnk_chg  = 3'd3,
    evt_mode_ack = 3'd4,
    evt_sys_rst  = 3'd5
  } evt_idx_e;

  typedef enum logic {
    axil_idle,
    axil_resp
  } axil_state_e;

endpackage

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pcie_cfg_checker \
  -f list.f -o sim_pcie_cfg_checker

out=$(./obj_dir/sim_pcie_cfg_checker || true)
echo "$out"

if grep -qx "TB PASSED" <<< "$out"; then
  exit 0
fi
echo "simulation did not pass"
exit 1

/* tb_clkgen.sv */
`timescale 1ns/1ns

module tb_clkgen (
  output logic sys_clk,
  output logic trn_clk,
  output logic mpu_clk,
  output logic rst_n
);

  // 8 ns, 10 ns and 12 ns periods, rising edges of sys_clk and mpu_clk never coincide
  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  initial begin
    trn_clk = 1'b0;
    forever #5 trn_clk = ~trn_clk;
  end

  initial begin
    mpu_clk = 1'b0;
    forever #6 mpu_clk = ~mpu_clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge sys_clk);
    @(negedge sys_clk);
    rst_n = 1'b1;
  end

endmodule

/* tb_pcie_cfg_checker.sv */
`timescale 1ns/1ns
`include "pcie_chk_cfg.svh"

module tb_pcie_cfg_checker;

  logic sys_clk;
  logic trn_clk;
  logic mpu_clk;
  logic rst_n;

  pcie_chk_pkg::bus_num_t  trn_bus_number;
  pcie_chk_pkg::dev_num_t  trn_device_number;
  pcie_chk_pkg::fn_num_t   trn_function_number;
  pcie_chk_pkg::cfg_word_t trn_command;
  pcie_chk_pkg::cfg_word_t trn_dstatus;
  pcie_chk_pkg::cfg_word_t trn_dcommand;
  pcie_chk_pkg::cfg_word_t trn_lstatus;
  pcie_chk_pkg::cfg_word_t trn_lcommand;
  pcie_chk_pkg::cfg_word_t trn_dcommand2;
  logic                    mode_ack;
  logic                    sys_rst_req;

  logic [`PCHK_ADDR_W-1:0]   awaddr;
  logic [`PCHK_ADDR_W-1:0]   araddr;
  logic [`PCHK_DATA_W-1:0]   wdata;
  logic [`PCHK_DATA_W-1:0]   rdata;
  logic [`PCHK_DATA_W/8-1:0] wstrb;
  logic [1:0]                bresp;
  logic [1:0]                rresp;
  logic                      awvalid;
  logic                      awready;
  logic                      wvalid;
  logic                      wready;
  logic                      bvalid;
  logic                      bready;
  logic                      arvalid;
  logic                      arready;
  logic                      rvalid;
  logic                      rready;

  pcie_chk_pkg::evt_vec_t mpu_evt_clear;
  pcie_chk_pkg::evt_vec_t mpu_evt_flags;
  logic                   mpu_mode_ack;
  logic                   mpu_sys_rst;

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     seen_mode_pulses = 0;
  int     seen_rst_pulses = 0;
  int     exp_mode_pulses = 0;
  int     exp_rst_pulses = 0;

  // reference model state
  pcie_chk_pkg::evt_cnt_t exp_cnt [`PCHK_EVT_COUNT];
  pcie_chk_pkg::evt_vec_t exp_flags;

  tb_clkgen u_clkgen (
    .sys_clk (sys_clk),
    .trn_clk (trn_clk),
    .mpu_clk (mpu_clk),
    .rst_n   (rst_n)
  );

  pcie_cfg_checker u_dut (.*);

  // mpu outputs change on the rising mpu edge
  always @(negedge mpu_clk) begin
    if (rst_n && mpu_mode_ack) seen_mode_pulses++;
    if (rst_n && mpu_sys_rst) seen_rst_pulses++;
  end

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  function automatic logic rand_ready();
    logic [31:0] r;
    r = $random(seed);
    return r[3] | r[7];
  endfunction

  task automatic finish_run();
    $display("closing report: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: %s did not arrive within 50 cycles", $time, what);
    errors++;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int n;
    @(negedge sys_clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    #1;
    while (!(awready && wready) && n < 50) begin
      @(negedge sys_clk);
      #1;
      n++;
    end
    if (!(awready && wready)) report_timeout("awready and wready");
    @(negedge sys_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = rand_ready();
    n = 0;
    #1;
    while (!(bvalid && bready) && n < 50) begin
      @(negedge sys_clk);
      bready = rand_ready();
      #1;
      n++;
    end
    if (!(bvalid && bready)) report_timeout("write response");
    check_val("bresp", bresp, 2'b00);
    @(negedge sys_clk);
    bready = 1'b0;
    #1;
    check_val("bvalid after response", bvalid, 1'b0);
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    int          n;
    logic        seen;
    logic [31:0] held;
    @(negedge sys_clk);
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    #1;
    while (!arready && n < 50) begin
      @(negedge sys_clk);
      #1;
      n++;
    end
    if (!arready) report_timeout("arready");
    @(negedge sys_clk);
    arvalid = 1'b0;
    rready  = rand_ready();
    seen = 1'b0;
    held = '0;
    n = 0;
    #1;
    while (!(rvalid && rready) && n < 50) begin
      if (rvalid && !seen) begin
        seen = 1'b1;
        held = rdata;
      end
      @(negedge sys_clk);
      rready = rand_ready();
      #1;
      n++;
    end
    if (!(rvalid && rready)) report_timeout("read response");
    if (seen) check_val("rdata under back-pressure", rdata, held);
    check_val("rresp", rresp, 2'b00);
    data = rdata;
    @(negedge sys_clk);
    rready = 1'b0;
    #1;
    check_val("rvalid after response", rvalid, 1'b0);
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] data;
    axi_read(addr, data);
    check_val(name, data, exp);
  endtask

  task automatic check_counters();
    for (int i = 0; i < `PCHK_EVT_COUNT; i++) begin
      read_check(8'(`PCHK_REG_CNT0 + 4 * i), 32'(exp_cnt[i]), $sformatf("cnt[%0d]", i));
    end
  endtask

  task automatic check_snapshot();
    read_check(`PCHK_REG_ID, {16'h0, trn_bus_number, trn_device_number, trn_function_number},
               "id register");
    read_check(`PCHK_REG_CMD, {trn_dstatus, trn_command}, "cmd register");
    read_check(`PCHK_REG_DCMD, {trn_dcommand2, trn_dcommand}, "dcmd register");
    read_check(`PCHK_REG_LNK, {trn_lstatus, trn_lcommand}, "lnk register");
  endtask

  task automatic clear_counters(input logic [31:0] data, input logic [3:0] strb);
    axi_write(`PCHK_REG_CLR, data, strb);
    for (int i = 0; i < `PCHK_EVT_COUNT; i++) begin
      if (strb[0] && data[i]) exp_cnt[i] = '0;
    end
  endtask

  task automatic clear_flags(input pcie_chk_pkg::evt_vec_t mask);
    @(negedge sys_clk);
    mpu_evt_clear = mask;
    repeat (4) @(negedge sys_clk);
    mpu_evt_clear = '0;
    exp_flags = exp_flags & ~mask;
    repeat (2) @(negedge sys_clk);
    check_val("mpu_evt_flags", mpu_evt_flags, exp_flags);
  endtask

  task automatic wait_flag(input int lane);
    int n;
    n = 0;
    while (!mpu_evt_flags[lane] && n < 50) begin
      @(negedge sys_clk);
      n++;
    end
    if (!mpu_evt_flags[lane]) report_timeout($sformatf("mpu_evt_flags[%0d]", lane));
  endtask

  task automatic apply_change();
    logic [31:0] r;
    logic [3:0]  old_err;
    int          kind;
    int          lane;
    r = next_rand();
    kind = r[7:0] % 9;
    lane = -1;
    @(negedge sys_clk);
    case (kind)
      0: begin
        {trn_bus_number, trn_device_number, trn_function_number} =
          {trn_bus_number, trn_device_number, trn_function_number} ^ (r[31:16] | 16'h1);
        lane = pcie_chk_pkg::evt_id_chg;
      end
      1: begin
        trn_command = trn_command ^ (r[31:16] | 16'h1);
        lane = pcie_chk_pkg::evt_cmd_chg;
      end
      2: begin
        old_err = trn_dstatus[3:0];
        trn_dstatus = r[31:16];
        if (|(trn_dstatus[3:0] & ~old_err)) lane = pcie_chk_pkg::evt_derr;
      end
      // upper status bits alone, then error bits falling, neither counts
      3: trn_dstatus = trn_dstatus ^ {r[27:16] | 12'h1, 4'h0};
      4: trn_dstatus[3:0] = trn_dstatus[3:0] & r[19:16];
      5: begin
        trn_lstatus = trn_lstatus ^ (r[31:16] | 16'h1);
        lane = pcie_chk_pkg::evt_lnk_chg;
      end
      6: begin
        case (r[9:8])
          2'd0: trn_lcommand = r[31:16];
          2'd1: trn_dcommand = r[31:16];
          default: trn_dcommand2 = r[31:16];
        endcase
      end
      7: begin
        mode_ack = 1'b1;
        lane = pcie_chk_pkg::evt_mode_ack;
      end
      default: begin
        sys_rst_req = 1'b1;
        lane = pcie_chk_pkg::evt_sys_rst;
      end
    endcase
    if (lane >= 0) begin
      if (exp_cnt[lane] != '1) exp_cnt[lane]++;
      exp_flags[lane] = 1'b1;
      if (lane == pcie_chk_pkg::evt_mode_ack) exp_mode_pulses++;
      if (lane == pcie_chk_pkg::evt_sys_rst) exp_rst_pulses++;
      wait_flag(lane);
    end
    @(negedge sys_clk);
    mode_ack    = 1'b0;
    sys_rst_req = 1'b0;
    repeat (20) @(negedge sys_clk);
    check_val("mpu_evt_flags", mpu_evt_flags, exp_flags);
    check_val("mpu_mode_ack pulses", seen_mode_pulses, exp_mode_pulses);
    check_val("mpu_sys_rst pulses", seen_rst_pulses, exp_rst_pulses);
  endtask

  initial begin
    logic [31:0] r;
    int          n;
    seed = 32'h48dbf8e7;
    {trn_bus_number, trn_device_number, trn_function_number} = next_rand();
    trn_command   = next_rand();
    trn_dstatus   = next_rand();
    trn_dcommand  = next_rand();
    trn_lstatus   = next_rand();
    trn_lcommand  = next_rand();
    trn_dcommand2 = next_rand();
    mode_ack      = 1'b0;
    sys_rst_req   = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    mpu_evt_clear = '0;
    exp_flags     = '0;
    for (int i = 0; i < `PCHK_EVT_COUNT; i++) exp_cnt[i] = '0;

    n = 0;
    while (!rst_n && n < 50) begin
      @(negedge sys_clk);
      n++;
    end
    if (!rst_n) report_timeout("reset release");
    repeat (2) @(negedge sys_clk);
    check_val("awready", awready, 1'b0);
    check_val("wready", wready, 1'b0);
    check_val("arready", arready, 1'b0);
    check_val("bvalid", bvalid, 1'b0);
    check_val("rvalid", rvalid, 1'b0);
    check_val("mpu_evt_flags", mpu_evt_flags, '0);
    check_val("mpu_mode_ack", mpu_mode_ack, 1'b0);
    check_val("mpu_sys_rst", mpu_sys_rst, 1'b0);
    check_counters();
    check_snapshot();

    for (int step = 0; step < 60; step++) begin
      apply_change();
      r = next_rand();
      clear_flags(r[`PCHK_EVT_COUNT-1:0]);
      clear_flags('1);
      if (step % 10 == 9) begin
        check_snapshot();
        check_counters();
      end
    end

    // writes off the clear register, or without byte lane 0, change nothing
    axi_write(`PCHK_REG_CMD, next_rand(), 4'hF);
    clear_counters(32'hFFFF_FFFF, 4'b1110);
    check_snapshot();
    check_counters();

    repeat (3) begin
      clear_counters(next_rand(), 4'hF);
      check_counters();
    end

    repeat (8) begin
      r = next_rand();
      read_check(8'h28 + 8'(r % 32'hD8), 32'h0, "rdata unmapped");
    end

    finish_run();
  end

endmodule
